// File: cap_sram.f
+incdir+rtl
rtl/cap_sram_mem_pkg.sv
rtl/cap_sram_cap_pkg.sv
rtl/cap_sram_lane_if.sv
rtl/cap_sram_front.sv
rtl/cap_sram_lane.sv
rtl/cap_sram_rsp.sv
rtl/cap_sram_top.sv
dv/cap_sram_assertions.sv
dv/cap_sram_tb.sv

// File: dv/cap_sram_assertions.sv
// ################################################
// Bound checker: shadow memory compare of read
// data, tags and read-valid timing.
// ################################################

`timescale 1ns/10ps

`include "cap_sram_params.svh"

module cap_sram_assertions (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          a_req_i,
  input logic                          a_we_i,
  input cap_sram_mem_pkg::byte_addr_t  a_addr_i,
  input cap_sram_mem_pkg::byte_en_t    a_be_i,
  input cap_sram_mem_pkg::data_t       a_wdata_i,
  input cap_sram_cap_pkg::cap_tag_t    a_wcap_i,
  input logic                          a_rvalid_o,
  input cap_sram_mem_pkg::data_t       a_rdata_o,
  input cap_sram_cap_pkg::cap_tag_t    a_rcap_o,
  input logic                          b_req_i,
  input cap_sram_mem_pkg::byte_addr_t  b_addr_i,
  input logic                          b_rvalid_o,
  input cap_sram_mem_pkg::data_t       b_rdata_o
);

  localparam int unsigned ByteOff = $clog2(`CAP_SRAM_DATA_W / 8);
  localparam int unsigned Words   = 2 ** `CAP_SRAM_WORD_AW;
  localparam int unsigned Groups  = Words >> `CAP_SRAM_TAG_OFF;

  // Shadow words with per-byte written flags.
  cap_sram_mem_pkg::data_t    shadow_mem [Words];
  cap_sram_mem_pkg::byte_en_t shadow_vld [Words];
  // Shadow tags, one per 64-bit group.
  cap_sram_cap_pkg::cap_tag_t shadow_tag [Groups];
  logic                       shadow_tag_vld [Groups];

  // Expected responses, captured at the issuing edge.
  cap_sram_mem_pkg::data_t    exp_a_data;
  cap_sram_mem_pkg::data_t    exp_a_mask;
  cap_sram_cap_pkg::cap_tag_t exp_a_tag;
  logic                       exp_a_tag_vld;
  cap_sram_mem_pkg::data_t    exp_b_data;
  cap_sram_mem_pkg::data_t    exp_b_mask;

  cap_sram_mem_pkg::word_addr_t a_word;
  cap_sram_mem_pkg::word_addr_t b_word;
  cap_sram_cap_pkg::tag_addr_t  a_group;
  logic                         a_rd;
  logic                         a_wr;
  logic                         a_ok;
  logic                         b_ok;

  // Failure count, read by the testbench.
  int unsigned fail_cnt = 0;

  // Byte flags widened to a bit mask.
  function automatic cap_sram_mem_pkg::data_t byte_mask(cap_sram_mem_pkg::byte_en_t be);
    cap_sram_mem_pkg::data_t m;
    for (int i = 0; i < `CAP_SRAM_NUM_LANES; i++) begin
      m[i*`CAP_SRAM_LANE_W +: `CAP_SRAM_LANE_W] = {`CAP_SRAM_LANE_W{be[i]}};
    end
    return m;
  endfunction

  assign a_word  = a_addr_i[`CAP_SRAM_ADDR_W-1:ByteOff];
  assign b_word  = b_addr_i[`CAP_SRAM_ADDR_W-1:ByteOff];
  assign a_group = a_word[`CAP_SRAM_WORD_AW-1:`CAP_SRAM_TAG_OFF];
  assign a_rd    = a_req_i & ~a_we_i;
  assign a_wr    = a_req_i & a_we_i;

  // Only bytes and tags written at least once are compared.
  assign a_ok = (((a_rdata_o ^ exp_a_data) & exp_a_mask) == '0) &&
                (!exp_a_tag_vld || a_rcap_o == exp_a_tag);
  assign b_ok = ((b_rdata_o ^ exp_b_data) & exp_b_mask) == '0;

  // Nothing written yet.
  initial begin
    for (int i = 0; i < Words; i++) begin
      shadow_vld[i] = '0;
    end
    for (int i = 0; i < Groups; i++) begin
      shadow_tag_vld[i] = 1'b0;
    end
  end

  // Reads see the contents before a same-edge write.
  always @(posedge clk_i) begin
    if (a_wr) begin
      for (int i = 0; i < `CAP_SRAM_NUM_LANES; i++) begin
        if (a_be_i[i]) begin
          shadow_mem[a_word][i*`CAP_SRAM_LANE_W +: `CAP_SRAM_LANE_W] <=
            a_wdata_i[i*`CAP_SRAM_LANE_W +: `CAP_SRAM_LANE_W];
          shadow_vld[a_word][i] <= 1'b1;
        end
      end
      // Any write to the group sets or clears its tag.
      shadow_tag[a_group]     <= a_wcap_i;
      shadow_tag_vld[a_group] <= 1'b1;
    end
    if (a_rd) begin
      exp_a_data    <= shadow_mem[a_word];
      exp_a_mask    <= byte_mask(shadow_vld[a_word]);
      exp_a_tag     <= shadow_tag[a_group];
      exp_a_tag_vld <= shadow_tag_vld[a_group];
    end
    if (b_req_i) begin
      exp_b_data <= shadow_mem[b_word];
      exp_b_mask <= byte_mask(shadow_vld[b_word]);
    end
  end

  reset_idle: assert property (@(posedge clk_i) !rst_ni |-> !a_rvalid_o && !b_rvalid_o)
    else begin
      fail_cnt++;
      $error("error at %0t: read valid high during reset", $time);
    end

  // Valid follows a read by exactly one cycle.
  a_valid_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    a_rvalid_o == $past(a_rd))
    else begin
      fail_cnt++;
      $error("error at %0t: port A rvalid not one cycle after a read", $time);
    end

  b_valid_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_rvalid_o == $past(b_req_i))
    else begin
      fail_cnt++;
      $error("error at %0t: port B rvalid not one cycle after a read", $time);
    end

  a_read_resp: assert property (@(posedge clk_i) disable iff (!rst_ni) a_rd |=> a_ok)
    else begin
      fail_cnt++;
      $error("error at %0t: port A data %h tag %b differ from shadow %h tag %b",
             $time, a_rdata_o, a_rcap_o, exp_a_data, exp_a_tag);
    end

  b_read_resp: assert property (@(posedge clk_i) disable iff (!rst_ni) b_req_i |=> b_ok)
    else begin
      fail_cnt++;
      $error("error at %0t: port B data %h differs from shadow %h",
             $time, b_rdata_o, exp_b_data);
    end

endmodule

// File: dv/cap_sram_tb.sv
// ################################################
// Testbench for the capability-tagged SRAM.
// ################################################

`timescale 1ns/10ps

`include "cap_sram_params.svh"

module cap_sram_tb;

  // Tests take about 520 cycles.
  localparam int unsigned MaxCycles = 2000;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          a_req_i;
  logic                          a_we_i;
  cap_sram_mem_pkg::byte_addr_t  a_addr_i;
  cap_sram_mem_pkg::byte_en_t    a_be_i;
  cap_sram_mem_pkg::data_t       a_wdata_i;
  cap_sram_cap_pkg::cap_tag_t    a_wcap_i;
  logic                          a_rvalid_o;
  cap_sram_mem_pkg::data_t       a_rdata_o;
  cap_sram_cap_pkg::cap_tag_t    a_rcap_o;
  logic                          b_req_i;
  cap_sram_mem_pkg::byte_addr_t  b_addr_i;
  logic                          b_rvalid_o;
  cap_sram_mem_pkg::data_t       b_rdata_o;

  int unsigned cycle_cnt    = 0;
  int unsigned tests_passed = 0;
  int unsigned tests_failed = 0;
  int unsigned fails_seen   = 0;

  cap_sram_top UUT (.*);

  // Shadow checker on the top-level ports.
  bind cap_sram_top cap_sram_assertions u_chk (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MaxCycles) begin
      $display("timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // One cycle of requests on both ports, then idle.
  task automatic issue(input logic a_req, input logic a_we, input int unsigned a_word,
                       input cap_sram_mem_pkg::byte_en_t be,
                       input cap_sram_mem_pkg::data_t wdata, input logic cap,
                       input logic b_req, input int unsigned b_word);
    a_req_i   = a_req;
    a_we_i    = a_we;
    // Random byte offset, ignored by the DUT.
    a_addr_i  = cap_sram_mem_pkg::byte_addr_t'((a_word << 2) | $urandom_range(3, 0));
    a_be_i    = be;
    a_wdata_i = wdata;
    a_wcap_i  = cap;
    b_req_i   = b_req;
    b_addr_i  = cap_sram_mem_pkg::byte_addr_t'((b_word << 2) | $urandom_range(3, 0));
    @(posedge clk_i);
    #1;
    a_req_i = 1'b0;
    b_req_i = 1'b0;
  endtask

  task automatic write_a(input int unsigned word, input cap_sram_mem_pkg::byte_en_t be,
                         input cap_sram_mem_pkg::data_t wdata, input logic cap);
    issue(1'b1, 1'b1, word, be, wdata, cap, 1'b0, 0);
  endtask

  task automatic read_a(input int unsigned word);
    issue(1'b1, 1'b0, word, '0, '0, 1'b0, 1'b0, 0);
  endtask

  task automatic read_b(input int unsigned word);
    issue(1'b0, 1'b0, 0, '0, '0, 1'b0, 1'b1, word);
  endtask

  // Lets the last response be checked, then reports.
  task automatic end_test(input string name);
    int unsigned now_fails;
    repeat (2) @(posedge clk_i);
    #1;
    now_fails = UUT.u_chk.fail_cnt;
    if (now_fails == fails_seen) begin
      tests_passed++;
      $display("test %-16s passed", name);
    end else begin
      tests_failed++;
      $display("test %-16s failed, %0d assertion failures", name, now_fails - fails_seen);
    end
    fails_seen = now_fails;
  endtask

  initial begin
    int unsigned w;
    void'($urandom(32'h1139));
    rst_ni    = 1'b1;
    a_req_i   = 1'b0;
    a_we_i    = 1'b0;
    a_addr_i  = '0;
    a_be_i    = '0;
    a_wdata_i = '0;
    a_wcap_i  = 1'b0;
    b_req_i   = 1'b0;
    b_addr_i  = '0;
    // Falling edge starts the asynchronous reset.
    #1;
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Idle, single reads, a write, then a read on both ports.
    repeat (2) @(posedge clk_i);
    #1;
    read_a(20);
    read_b(21);
    write_a(20, 4'hf, 32'h1234_5678, 1'b0);
    issue(1'b1, 1'b0, 20, '0, '0, 1'b0, 1'b1, 20);
    end_test("rvalid_timing");

    for (int i = 0; i < 8; i++) begin
      write_a(i, 4'hf, $urandom(), 1'b0);
    end
    // Read back in reverse order.
    for (int i = 0; i < 8; i++) begin
      read_a(7 - i);
    end
    end_test("full_write_read");

    for (int i = 0; i < 16; i++) begin
      w = $urandom_range(1023, 64);
      write_a(w, 4'hf, $urandom(), 1'b0);
      write_a(w, cap_sram_mem_pkg::byte_en_t'($urandom()), $urandom(), 1'b0);
      read_a(w);
    end
    end_test("partial_write");

    for (int i = 0; i < 8; i++) begin
      read_b(i);
    end
    // Port B sees the old word while A writes it.
    issue(1'b1, 1'b1, 3, 4'hf, 32'hdead_beef, 1'b0, 1'b1, 3);
    read_b(3);
    end_test("port_b_read");

    // Group of words 40 and 41.
    write_a(40, 4'hf, 32'hc0de_0001, 1'b1);
    read_a(40);
    read_a(41);
    write_a(41, 4'h0, '0, 1'b0);
    read_a(40);
    read_a(41);
    write_a(41, 4'hf, 32'hc0de_0002, 1'b1);
    read_a(40);
    write_a(40, 4'hf, 32'hc0de_0003, 1'b0);
    read_a(41);
    read_a(40);
    end_test("cap_tags");

    // Small window so reads often hit written words.
    for (int i = 0; i < 400; i++) begin
      issue($urandom_range(3, 0) != 0, $urandom_range(1, 0), $urandom_range(63, 0),
            cap_sram_mem_pkg::byte_en_t'($urandom()), $urandom(), $urandom_range(1, 0),
            $urandom_range(1, 0), $urandom_range(63, 0));
    end
    end_test("random_mix");

    $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
             tests_passed, tests_failed, fails_seen);
    if (tests_failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: rtl/cap_sram_cap_pkg.sv
// ################################################
// Capability tag types.
// ################################################

`include "cap_sram_params.svh"

package cap_sram_cap_pkg;

  // Valid-capability marker for a 64-bit group.
  typedef logic cap_tag_t;
  // Tag store index, word address minus the group bits.
  typedef logic [`CAP_SRAM_WORD_AW-`CAP_SRAM_TAG_OFF-1:0] tag_addr_t;

endpackage

// File: rtl/cap_sram_front.sv
// ################################################
// Front end: byte address to word command decode.
// ################################################

`timescale 1ns/10ps

`include "cap_sram_params.svh"

module cap_sram_front (
  // Port A, data port.
  input  logic                          a_req_i,
  input  logic                          a_we_i,
  input  cap_sram_mem_pkg::byte_addr_t  a_addr_i,
  input  cap_sram_mem_pkg::byte_en_t    a_be_i,
  input  cap_sram_mem_pkg::data_t       a_wdata_i,
  // Port B, fetch port.
  input  logic                          b_req_i,
  input  cap_sram_mem_pkg::byte_addr_t  b_addr_i,
  // Commands to lanes and response stage.
  cap_sram_lane_if.front                cmd
);

  // Byte offset bits inside one word.
  localparam int unsigned ByteOff = $clog2(`CAP_SRAM_DATA_W / 8);

  // Combined request and write, per-lane enables derive from it.
  logic a_wr;

  assign a_wr = a_req_i & a_we_i;

  // Port A command.
  assign cmd.a_req   = a_req_i;
  assign cmd.a_we    = a_we_i;
  // Low address bits ignored, word aligned access.
  assign cmd.a_addr  = a_addr_i[`CAP_SRAM_ADDR_W-1:ByteOff];
  assign cmd.a_wdata = a_wdata_i;

  // Lanes only write on a real write request.
  assign cmd.a_lane_we = {`CAP_SRAM_NUM_LANES{a_wr}} & a_be_i;

  // Port B never writes.
  // Only its request and word address go to the lanes.
  assign cmd.b_req  = b_req_i;
  assign cmd.b_addr = b_addr_i[`CAP_SRAM_ADDR_W-1:ByteOff];

endmodule

// File: rtl/cap_sram_lane.sv
// ################################################
// One byte lane of the two-port data RAM.
// Registered reads on both ports.
// ################################################

`timescale 1ns/10ps

`include "cap_sram_params.svh"

module cap_sram_lane #(
  // Lane position inside the data word.
  parameter int unsigned LANE_IDX = 0
) (
  input  logic                          clk_i,
  cap_sram_lane_if.lane                 cmd,
  output cap_sram_mem_pkg::lane_data_t  a_rdata_o,
  output cap_sram_mem_pkg::lane_data_t  b_rdata_o
);

  localparam int unsigned Depth = 2 ** `CAP_SRAM_WORD_AW;

  // Lane storage, contents undefined until written.
  cap_sram_mem_pkg::lane_data_t mem [Depth];

  // Read holding registers.
  cap_sram_mem_pkg::lane_data_t a_rdata_q;
  cap_sram_mem_pkg::lane_data_t b_rdata_q;

  // Port A, write of this lane's slice or a read.
  always_ff @(posedge clk_i) begin
    if (cmd.a_lane_we[LANE_IDX]) begin
      mem[cmd.a_addr] <= cmd.a_wdata[LANE_IDX*`CAP_SRAM_LANE_W +: `CAP_SRAM_LANE_W];
    end else if (cmd.a_req && !cmd.a_we) begin
      a_rdata_q <= mem[cmd.a_addr];
    end
  end

  // Port B read.
  // Same-edge write from A is not yet visible, old byte returned.
  always_ff @(posedge clk_i) begin
    if (cmd.b_req) begin
      b_rdata_q <= mem[cmd.b_addr];
    end
  end

  assign a_rdata_o = a_rdata_q;
  assign b_rdata_o = b_rdata_q;

endmodule

// File: rtl/cap_sram_lane_if.sv
// ################################################
// Word-level command bundle, front end to lanes.
// ################################################

`timescale 1ns/10ps

interface cap_sram_lane_if;

  // Port A, read or write.
  logic                          a_req;
  logic                          a_we;
  cap_sram_mem_pkg::word_addr_t  a_addr;
  // Already gated with request and write.
  cap_sram_mem_pkg::byte_en_t    a_lane_we;
  cap_sram_mem_pkg::data_t       a_wdata;

  // Port B, read only.
  logic                          b_req;
  cap_sram_mem_pkg::word_addr_t  b_addr;

  // Decoder side.
  modport front (
    output a_req, a_we, a_addr, a_lane_we, a_wdata,
    output b_req, b_addr
  );

  // Byte lanes.
  modport lane (
    input  a_req, a_we, a_addr, a_lane_we, a_wdata,
    input  b_req, b_addr
  );

  // Tag store and valid pulses, no data needed.
  modport rsp (
    input  a_req, a_we, a_addr,
    input  b_req, b_addr
  );

endinterface

// File: rtl/cap_sram_mem_pkg.sv
// ################################################
// Data memory types: addresses, words and lanes.
// ################################################

`include "cap_sram_params.svh"

package cap_sram_mem_pkg;

  // Byte address as seen at the ports.
  typedef logic [`CAP_SRAM_ADDR_W-1:0]    byte_addr_t;
  // Word index into every lane.
  typedef logic [`CAP_SRAM_WORD_AW-1:0]   word_addr_t;
  // Full bus word.
  typedef logic [`CAP_SRAM_DATA_W-1:0]    data_t;
  // Slice held by one lane.
  typedef logic [`CAP_SRAM_LANE_W-1:0]    lane_data_t;
  // One enable per lane.
  typedef logic [`CAP_SRAM_NUM_LANES-1:0] byte_en_t;

endpackage

// File: rtl/cap_sram_params.svh
// ################################################
// Capability-tagged SRAM size and layout constants.
// ################################################

`ifndef CAP_SRAM_PARAMS_SVH
`define CAP_SRAM_PARAMS_SVH

// Byte address width, 4 KiB of data.
`define CAP_SRAM_ADDR_W    12
`define CAP_SRAM_DATA_W    32
`define CAP_SRAM_LANE_W    8
`define CAP_SRAM_NUM_LANES (`CAP_SRAM_DATA_W / `CAP_SRAM_LANE_W)
// Word address, byte offset stripped.
`define CAP_SRAM_WORD_AW   10
// One tag per two 32-bit words.
`define CAP_SRAM_TAG_OFF   1

`endif

// File: rtl/cap_sram_rsp.sv
// ################################################
// Response stage: tag store, read merge and
// read-valid pulses for both ports.
// ################################################

`timescale 1ns/10ps

`include "cap_sram_params.svh"

module cap_sram_rsp (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  cap_sram_lane_if.rsp                  cmd,
  // Set on a capability store.
  input  cap_sram_cap_pkg::cap_tag_t    a_wcap_i,
  // Lane read bytes, already concatenated.
  input  cap_sram_mem_pkg::data_t       a_lane_rdata_i,
  input  cap_sram_mem_pkg::data_t       b_lane_rdata_i,
  // Port A response.
  output logic                          a_rvalid_o,
  output cap_sram_mem_pkg::data_t       a_rdata_o,
  output cap_sram_cap_pkg::cap_tag_t    a_rcap_o,
  // Port B response.
  output logic                          b_rvalid_o,
  output cap_sram_mem_pkg::data_t       b_rdata_o
);

  localparam int unsigned TagDepth = 2 ** (`CAP_SRAM_WORD_AW - `CAP_SRAM_TAG_OFF);

  // One tag per 64-bit group.
  cap_sram_cap_pkg::cap_tag_t tag_mem [TagDepth];

  cap_sram_cap_pkg::tag_addr_t tag_idx;
  cap_sram_cap_pkg::cap_tag_t  a_rcap_q;

  logic a_rd;
  logic a_wr;
  logic a_rvalid_q;
  logic b_rvalid_q;

  // Drop the word-in-group bit.
  assign tag_idx = cmd.a_addr[`CAP_SRAM_WORD_AW-1:`CAP_SRAM_TAG_OFF];

  assign a_wr = cmd.a_req & cmd.a_we;
  assign a_rd = cmd.a_req & ~cmd.a_we;

  // Every write updates the tag, even with no byte enabled.
  // Read kept in step with the lane read registers.
  always_ff @(posedge clk_i) begin
    if (a_wr) begin
      tag_mem[tag_idx] <= a_wcap_i;
    end else if (a_rd) begin
      a_rcap_q <= tag_mem[tag_idx];
    end
  end

  // One-cycle valid pulses, reads only.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_rvalid_q <= 1'b0;
      b_rvalid_q <= 1'b0;
    end else begin
      a_rvalid_q <= a_rd;
      b_rvalid_q <= cmd.b_req;
    end
  end

  assign a_rvalid_o = a_rvalid_q;
  assign a_rdata_o  = a_lane_rdata_i;
  assign a_rcap_o   = a_rcap_q;

  assign b_rvalid_o = b_rvalid_q;
  assign b_rdata_o  = b_lane_rdata_i;

endmodule

// File: rtl/cap_sram_top.sv
// ################################################
// Capability-tagged dual-port data memory, top.
// ################################################

`timescale 1ns/10ps

`include "cap_sram_params.svh"

module cap_sram_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Port A, data port with tags.
  input  logic                          a_req_i,
  input  logic                          a_we_i,
  input  cap_sram_mem_pkg::byte_addr_t  a_addr_i,
  input  cap_sram_mem_pkg::byte_en_t    a_be_i,
  input  cap_sram_mem_pkg::data_t       a_wdata_i,
  input  cap_sram_cap_pkg::cap_tag_t    a_wcap_i,
  output logic                          a_rvalid_o,
  output cap_sram_mem_pkg::data_t       a_rdata_o,
  output cap_sram_cap_pkg::cap_tag_t    a_rcap_o,
  // Port B, read-only fetch port.
  input  logic                          b_req_i,
  input  cap_sram_mem_pkg::byte_addr_t  b_addr_i,
  output logic                          b_rvalid_o,
  output cap_sram_mem_pkg::data_t       b_rdata_o
);

  // Per-cycle word commands.
  cap_sram_lane_if cmd ();

  // Lane read bytes gathered into words.
  cap_sram_mem_pkg::data_t a_lane_rdata;
  cap_sram_mem_pkg::data_t b_lane_rdata;

  cap_sram_front u_front (
    .a_req_i   (a_req_i),
    .a_we_i    (a_we_i),
    .a_addr_i  (a_addr_i),
    .a_be_i    (a_be_i),
    .a_wdata_i (a_wdata_i),
    .b_req_i   (b_req_i),
    .b_addr_i  (b_addr_i),
    .cmd       (cmd.front)
  );

  // One RAM per byte lane.
  for (genvar i = 0; i < `CAP_SRAM_NUM_LANES; i++) begin : g_lane
    cap_sram_lane #(
      .LANE_IDX (i)
    ) u_lane (
      .clk_i     (clk_i),
      .cmd       (cmd.lane),
      .a_rdata_o (a_lane_rdata[i*`CAP_SRAM_LANE_W +: `CAP_SRAM_LANE_W]),
      .b_rdata_o (b_lane_rdata[i*`CAP_SRAM_LANE_W +: `CAP_SRAM_LANE_W])
    );
  end

  // Tags and response valids.
  cap_sram_rsp u_rsp (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd            (cmd.rsp),
    .a_wcap_i       (a_wcap_i),
    .a_lane_rdata_i (a_lane_rdata),
    .b_lane_rdata_i (b_lane_rdata),
    .a_rvalid_o     (a_rvalid_o),
    .a_rdata_o      (a_rdata_o),
    .a_rcap_o       (a_rcap_o),
    .b_rvalid_o     (b_rvalid_o),
    .b_rdata_o      (b_rdata_o)
  );

endmodule
